// File: build.f
hdl/r2_cfg_pkg.sv
hdl/r2_data_pkg.sv
hdl/r2_controller.sv
hdl/r2_window_sum.sv
hdl/r2_prefix_sum.sv
hdl/r2_row_merge.sv
hdl/r2_stage.sv
testbench/r2_stage_assert.sv
testbench/r2_stage_tb.sv

// File: Makefile
SRCS := $(shell cat build.f)

.PHONY: all run clean

all: obj_dir/Vr2_stage_tb

# Rebuilt only when a source or the file list changes.
obj_dir/V%: $(SRCS) build.f
	verilator --binary --assert -j 0 --top-module $* -f build.f

run: obj_dir/Vr2_stage_tb
	@out="$$(./obj_dir/Vr2_stage_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: testbench/r2_stage_tb.sv
`timescale 1ns/100ps

module r2_stage_tb;

    import r2_cfg_pkg::*;
    import r2_data_pkg::*;

    localparam int FRAMES        = 3;
    localparam int CLK_HALF      = 20;
    localparam int DRIVE_DLY     = 2;
    localparam int WORDS_PER_ROW = COLS - WIN + 1;
    localparam int DONE_LIMIT    = 2 * (COLS + 8);
    localparam int WATCH_CYCLES  = FRAMES * ROWS * (COLS + 8) + 50;

    logic    clk;
    logic    rst;
    logic    i_row_ready;
    r2_pix_t i_pix;
    logic    i_frame_start;
    r2_out_t o_out;
    logic    o_frame_done;
    logic    o_busy;

    logic [PIX_W-1:0] img [ROWS][COLS];
    logic [31:0]      rng_state;
    r2_out_t          expect_q [$];
    string            name_q [$];
    r2_out_t          exp_w;
    string            exp_name;
    int               mismatch_errors = 0;
    int               stray_errors    = 0;
    int               done_errors     = 0;
    int               other_errors    = 0;
    int               word_count      = 0;
    int               done_count      = 0;
    int               words_sent      = 0;
    int               assert_errors   = 0;
    int               protocol_errors = 0;

    r2_stage dut_i (
        .clk          (clk),
        .rst          (rst),
        .i_row_ready  (i_row_ready),
        .i_pix        (i_pix),
        .i_frame_start(i_frame_start),
        .o_out        (o_out),
        .o_frame_done (o_frame_done),
        .o_busy       (o_busy)
    );

    bind r2_controller r2_stage_assert assert_i (
        .clk         (clk),
        .rst         (rst),
        .i_ctrl      (o_ctrl),
        .i_frame_done(o_frame_done),
        .i_busy      (o_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // *************************************************************************
    // Reference model.
    // *************************************************************************
    // Window covers columns c-WIN+1 to c, the running sum columns 0 to c.
    function automatic r2_out_t expected_word(input int r, input int c);
        r2_out_t w;
        int      win_acc;
        int      cum_acc;
        win_acc = 0;
        cum_acc = 0;
        for (int k = 0; k <= c; k++) begin
            cum_acc += int'(img[r][k]);
            if (k > c - WIN) begin
                win_acc += int'(img[r][k]);
            end
        end
        w.valid    = 1'b1;
        w.win_sum  = SUM_W'(win_acc);
        w.cum_sum  = SUM_W'(cum_acc);
        w.col      = COL_W'(c);
        w.row_last = (c == COLS - 1);
        return w;
    endfunction

    task automatic fill_row(input int r, input bit saturate);
        for (int c = 0; c < COLS; c++) begin
            rng_state = xorshift32(rng_state);
            img[r][c] = saturate ? '1 : rng_state[PIX_W-1:0];
        end
    endtask

    task automatic queue_row(input string kind, input int f, input int r);
        for (int c = WIN - 1; c < COLS; c++) begin
            expect_q.push_back(expected_word(r, c));
            name_q.push_back($sformatf("%s_frame%0d_row%0d_col%0d", kind, f, r, c));
        end
    endtask

    task automatic start_frame();
        @(posedge clk);
        #(DRIVE_DLY);
        i_frame_start = 1'b1;
        @(posedge clk);
        #(DRIVE_DLY);
        i_frame_start = 1'b0;
    endtask

    task automatic send_row(input int r);
        @(posedge clk);
        #(DRIVE_DLY);
        i_row_ready = 1'b1;
        for (int c = 0; c < COLS; c++) begin
            @(posedge clk);
            #(DRIVE_DLY);
            i_row_ready = 1'b0;
            i_pix.valid = 1'b1;
            i_pix.pix   = img[r][c];
        end
        @(posedge clk);
        #(DRIVE_DLY);
        i_pix = '0;
        // Row pulses stay COLS+4 cycles apart.
        repeat (2) @(posedge clk);
    endtask

    task automatic wait_frame_done(input int expected);
        int waited;
        waited = 0;
        while (done_count < expected && waited < DONE_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (done_count < expected) begin
            $display("frame done pulse missing %0d cycles after the last row", DONE_LIMIT);
            other_errors++;
        end
    endtask

    // *************************************************************************
    // Output checking.
    // *************************************************************************
    always @(negedge clk) begin
        if (!rst && o_out.valid === 1'b1) begin
            word_count++;
            if (expect_q.size() == 0) begin
                $display("output word for column %0d arrived with none expected", o_out.col);
                stray_errors++;
            end else begin
                exp_w    = expect_q.pop_front();
                exp_name = name_q.pop_front();
                if (o_out.win_sum !== exp_w.win_sum) begin
                    $display("MISMATCH %s win_sum: expected %0d, actual %0d",
                             exp_name, exp_w.win_sum, o_out.win_sum);
                    mismatch_errors++;
                end
                if (o_out.cum_sum !== exp_w.cum_sum) begin
                    $display("MISMATCH %s cum_sum: expected %0d, actual %0d",
                             exp_name, exp_w.cum_sum, o_out.cum_sum);
                    mismatch_errors++;
                end
                if (o_out.col !== exp_w.col) begin
                    $display("MISMATCH %s col: expected %0d, actual %0d",
                             exp_name, exp_w.col, o_out.col);
                    mismatch_errors++;
                end
                if (o_out.row_last !== exp_w.row_last) begin
                    $display("MISMATCH %s row_last: expected %0b, actual %0b",
                             exp_name, exp_w.row_last, o_out.row_last);
                    mismatch_errors++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && o_frame_done === 1'b1) begin
            done_count++;
            if (o_busy !== 1'b0) begin
                $display("busy still high during the frame done pulse");
                done_errors++;
            end
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCH_CYCLES);
        $display("tests failed");
        $finish;
    end

    // *************************************************************************
    // Main sequence.
    // *************************************************************************
    initial begin
        rst           = 1'b1;
        i_row_ready   = 1'b0;
        i_frame_start = 1'b0;
        i_pix         = '0;
        rng_state     = 32'hb6070564;
        repeat (2) @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b0;
        @(negedge clk);
        if (o_busy !== 1'b0 || o_frame_done !== 1'b0 || o_out.valid !== 1'b0) begin
            $display("outputs not idle after reset");
            other_errors++;
        end

        // Frame 1 is all 255, the others random.
        for (int f = 0; f < FRAMES; f++) begin
            start_frame();
            @(negedge clk);
            if (o_busy !== 1'b1) begin
                $display("busy did not rise after frame start %0d", f);
                other_errors++;
            end
            for (int r = 0; r < ROWS; r++) begin
                fill_row(r, f == 1);
                queue_row((f == 1) ? "saturated" : "random", f, r);
                send_row(r);
                words_sent += WORDS_PER_ROW;
                if (word_count != words_sent) begin
                    $display("frame %0d row %0d left %0d words in total, %0d wanted",
                             f, r, word_count, words_sent);
                    other_errors++;
                end
            end
            wait_frame_done(f + 1);
            repeat (4) @(posedge clk);
            if (done_count != f + 1) begin
                $display("frame %0d ended with %0d frame done pulses in total", f, done_count);
                other_errors++;
            end
            if (o_busy !== 1'b0) begin
                $display("busy still high after frame %0d", f);
                other_errors++;
            end
        end

        repeat (4) @(posedge clk);
        if (expect_q.size() != 0) begin
            $display("%0d expected words never appeared", expect_q.size());
            other_errors++;
        end
        assert_errors = dut_i.ctrl_i.assert_i.ld_sum_fails
                      + dut_i.ctrl_i.assert_i.done_width_fails
                      + dut_i.ctrl_i.assert_i.busy_fails;
        protocol_errors = other_errors + stray_errors + done_errors;
        $display("errors: %0d mismatch, %0d protocol, %0d assertion",
                 mismatch_errors, protocol_errors, assert_errors);
        if (mismatch_errors + protocol_errors + assert_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: testbench/r2_stage_assert.sv
`timescale 1ns/100ps

module r2_stage_assert (
    input logic                  clk,
    input logic                  rst,
    input r2_data_pkg::r2_ctrl_t i_ctrl,
    input logic                  i_frame_done,
    input logic                  i_busy
);

    import r2_cfg_pkg::*;

    int ld_sum_fails     = 0;
    int done_width_fails = 0;
    int busy_fails       = 0;

    // Window output starts WIN-1 cycles after the row load and never overlaps it.
    ld_sum_excl: assert property (
        @(posedge clk) disable iff (rst)
            i_ctrl.sum_en |-> !i_ctrl.ld_en
                              && ($past(i_ctrl.sum_en) || $past(i_ctrl.ld_en, WIN - 1))
    ) else begin
        $error("sum_en high with ld_en or not WIN-1 cycles after a row load");
        ld_sum_fails++;
    end

    // Frame done is a single cycle shortly after a row end.
    done_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
            i_frame_done |-> !$past(i_frame_done)
                             && ($past(i_ctrl.row_last, 3) || $past(i_ctrl.row_last, 4)
                                 || $past(i_ctrl.row_last, 5))
    ) else begin
        $error("frame done pulse longer than one cycle or not after a row end");
        done_width_fails++;
    end

    // Sequencer sits in idle during and right after reset.
    busy_after_reset: assert property (
        @(posedge clk) (rst || $fell(rst)) |-> !i_busy
    ) else begin
        $error("busy high during or right after reset");
        busy_fails++;
    end

endmodule

// File: hdl/r2_stage.sv
`timescale 1ns/100ps

module r2_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_row_ready,
    input  r2_data_pkg::r2_pix_t i_pix,
    input  logic                 i_frame_start,
    output r2_data_pkg::r2_out_t o_out,
    output logic                 o_frame_done,
    output logic                 o_busy
);

    import r2_cfg_pkg::*;
    import r2_data_pkg::*;

    r2_ctrl_t         ctrl;
    logic [SUM_W-1:0] win_sum;
    logic             win_valid;
    logic [SUM_W-1:0] cum_sum;
    logic             cum_valid;

    r2_controller ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .i_row_ready  (i_row_ready),
        .i_frame_start(i_frame_start),
        .i_pix_valid  (i_pix.valid),
        .o_ctrl       (ctrl),
        .o_frame_done (o_frame_done),
        .o_busy       (o_busy)
    );

    // Both sums see the same pixel stream in parallel.
    r2_window_sum win_i (
        .clk      (clk),
        .rst      (rst),
        .i_pix    (i_pix),
        .i_ld_en  (ctrl.ld_en),
        .i_sum_en (ctrl.sum_en),
        .o_win_sum(win_sum),
        .o_valid  (win_valid)
    );

    r2_prefix_sum cum_i (
        .clk      (clk),
        .rst      (rst),
        .i_pix    (i_pix),
        .i_ld_en  (ctrl.ld_en),
        .i_cum_en (ctrl.cum_en),
        .o_cum_sum(cum_sum),
        .o_valid  (cum_valid)
    );

    r2_row_merge merge_i (
        .clk        (clk),
        .rst        (rst),
        .i_win_sum  (win_sum),
        .i_win_valid(win_valid),
        .i_cum_sum  (cum_sum),
        .i_cum_valid(cum_valid),
        .i_ctrl     (ctrl),
        .o_out      (o_out)
    );

endmodule

// File: hdl/r2_row_merge.sv
`timescale 1ns/100ps

module r2_row_merge (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [r2_cfg_pkg::SUM_W-1:0] i_win_sum,
    input  logic                         i_win_valid,
    input  logic [r2_cfg_pkg::SUM_W-1:0] i_cum_sum,
    input  logic                         i_cum_valid,
    input  r2_data_pkg::r2_ctrl_t        i_ctrl,
    output r2_data_pkg::r2_out_t         o_out
);

    import r2_cfg_pkg::*;

    logic [COL_W-1:0] col_q;
    logic             last_q;
    logic             both_valid;
    logic             out_valid;
    logic             out_last;
    logic [SUM_W-1:0] out_win;
    logic [SUM_W-1:0] out_cum;
    logic [COL_W-1:0] out_col;

    // Column and row end trail the sums by one register.
    always_ff @(posedge clk) begin
        col_q <= i_ctrl.col;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q    <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            last_q    <= i_ctrl.row_last;
            out_valid <= both_valid;
            out_last  <= both_valid && last_q;
        end
    end

    assign both_valid = i_win_valid && i_cum_valid;

    always_ff @(posedge clk) begin
        if (both_valid) begin
            out_win <= i_win_sum;
            out_cum <= i_cum_sum;
            out_col <= col_q;
        end
    end

    always_comb begin
        o_out.valid    = out_valid;
        o_out.win_sum  = out_win;
        o_out.cum_sum  = out_cum;
        o_out.col      = out_col;
        o_out.row_last = out_last;
    end

endmodule

// File: hdl/r2_prefix_sum.sv
`timescale 1ns/100ps

module r2_prefix_sum (
    input  logic                         clk,
    input  logic                         rst,
    input  r2_data_pkg::r2_pix_t         i_pix,
    input  logic                         i_ld_en,
    input  logic                         i_cum_en,
    output logic [r2_cfg_pkg::SUM_W-1:0] o_cum_sum,
    output logic                         o_valid
);

    import r2_cfg_pkg::*;

    logic [SUM_W-1:0] acc_q;
    logic [SUM_W-1:0] pix_ext;

    assign pix_ext = SUM_W'(i_pix.pix);

    // The first pixel of a row replaces the previous total.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_q <= '0;
        end else if (i_ld_en) begin
            acc_q <= pix_ext;
        end else if (i_pix.valid) begin
            acc_q <= acc_q + pix_ext;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_cum_en;
        end
    end

    assign o_cum_sum = acc_q;

endmodule

// File: hdl/r2_window_sum.sv
`timescale 1ns/100ps

module r2_window_sum (
    input  logic                         clk,
    input  logic                         rst,
    input  r2_data_pkg::r2_pix_t         i_pix,
    input  logic                         i_ld_en,
    input  logic                         i_sum_en,
    output logic [r2_cfg_pkg::SUM_W-1:0] o_win_sum,
    output logic                         o_valid
);

    import r2_cfg_pkg::*;

    logic [PIX_W-1:0] win_q [WIN];
    logic [SUM_W-1:0] total_q;
    logic [SUM_W-1:0] newest;
    logic [SUM_W-1:0] oldest;

    assign newest = SUM_W'(i_pix.pix);
    assign oldest = SUM_W'(win_q[WIN-1]);

    // Shift window. Entry 0 is the newest pixel.
    always_ff @(posedge clk) begin
        if (i_ld_en) begin
            win_q[0] <= i_pix.pix;
            for (int i = 1; i < WIN; i++) begin
                win_q[i] <= '0;
            end
        end else if (i_pix.valid) begin
            win_q[0] <= i_pix.pix;
            for (int i = 1; i < WIN; i++) begin
                win_q[i] <= win_q[i-1];
            end
        end
    end

    // Running total, add newest and drop oldest.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            total_q <= '0;
        end else if (i_ld_en) begin
            total_q <= newest;
        end else if (i_pix.valid) begin
            total_q <= total_q + newest - oldest;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_sum_en;
        end
    end

    assign o_win_sum = total_q;

endmodule

// File: hdl/r2_controller.sv
`timescale 1ns/100ps

module r2_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_row_ready,
    input  logic                  i_frame_start,
    input  logic                  i_pix_valid,
    output r2_data_pkg::r2_ctrl_t o_ctrl,
    output logic                  o_frame_done,
    output logic                  o_busy
);

    import r2_cfg_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE      = 3'd0,
        S_START     = 3'd1,
        S_START_ROW = 3'd2,
        S_SUM       = 3'd3,
        S_CUM       = 3'd4,
        S_FINISH    = 3'd5,
        S_DONE      = 3'd6
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [COL_W-1:0] stretch_cnt;
    logic             stretch_on;
    logic             row_active;
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic             in_row;
    logic             row_end;
    logic             frame_last;

    // *************************************************************************
    // Row ready stretcher and counters.
    // *************************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stretch_cnt <= '0;
            stretch_on  <= 1'b0;
        end else if (i_row_ready) begin
            stretch_cnt <= '0;
            stretch_on  <= 1'b1;
        end else if (stretch_on && stretch_cnt < COL_W'(COLS)) begin
            stretch_cnt <= stretch_cnt + 1'b1;
        end else begin
            stretch_cnt <= '0;
            stretch_on  <= 1'b0;
        end
    end

    assign row_active = i_row_ready | stretch_on;

    // Column index of the pixel on the input this cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col_cnt <= '0;
        end else if (i_row_ready) begin
            col_cnt <= '0;
        end else if (row_active && i_pix_valid) begin
            col_cnt <= col_cnt + 1'b1;
        end
    end

    assign row_end    = (state == S_CUM) && i_pix_valid && (col_cnt == COL_W'(COLS - 1));
    assign frame_last = (row_cnt == ROW_W'(ROWS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_cnt <= '0;
        end else if (i_frame_start) begin
            row_cnt <= '0;
        end else if (row_end && !frame_last) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // *************************************************************************
    // Sequencer.
    // *************************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (i_frame_start) begin
                    next_state = S_START;
                end
            end
            S_START: begin
                if (i_row_ready) begin
                    next_state = S_START_ROW;
                end
            end
            S_START_ROW: begin
                if (!row_active) begin
                    next_state = S_FINISH;
                end else if (i_pix_valid) begin
                    next_state = S_SUM;
                end
            end
            // Window still filling.
            S_SUM: begin
                if (!row_active) begin
                    next_state = S_FINISH;
                end else if (i_pix_valid && col_cnt == COL_W'(WIN - 2)) begin
                    next_state = S_CUM;
                end
            end
            S_CUM: begin
                if (!row_active) begin
                    next_state = S_FINISH;
                end else if (row_end) begin
                    next_state = frame_last ? S_FINISH : S_START;
                end
            end
            S_FINISH: next_state = S_DONE;
            S_DONE:   next_state = S_IDLE;
            default:  next_state = S_IDLE;
        endcase
    end

    assign in_row = ((state == S_START_ROW) || (state == S_SUM) || (state == S_CUM))
                    && i_pix_valid;

    always_comb begin
        o_ctrl.ld_en    = (state == S_START_ROW) && i_pix_valid;
        o_ctrl.sum_en   = (state == S_CUM) && i_pix_valid;
        o_ctrl.cum_en   = in_row;
        o_ctrl.row_last = row_end;
        o_ctrl.col      = col_cnt;
    end

    // Frame done lands one cycle after the last output word.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_frame_done <= 1'b0;
        end else begin
            o_frame_done <= (state == S_DONE);
        end
    end

    assign o_busy = (state != S_IDLE);

endmodule

// File: hdl/r2_data_pkg.sv
package r2_data_pkg;

    import r2_cfg_pkg::*;

    // Pixel as delivered by the column stage.
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] pix;
    } r2_pix_t;

    // Controller strobes, valid in the cycle of the current pixel.
    typedef struct packed {
        logic             ld_en;
        logic             sum_en;
        logic             cum_en;
        logic             row_last;
        logic [COL_W-1:0] col;
    } r2_ctrl_t;

    // One result per pixel position.
    typedef struct packed {
        logic             valid;
        logic [SUM_W-1:0] win_sum;
        logic [SUM_W-1:0] cum_sum;
        logic [COL_W-1:0] col;
        logic             row_last;
    } r2_out_t;

endpackage

// File: hdl/r2_cfg_pkg.sv
package r2_cfg_pkg;

    // *************************************************************************
    // Image geometry.
    // *************************************************************************
    localparam int COLS = 16;
    localparam int ROWS = 4;

    // The first full window ends on column WIN-1.
    localparam int WIN = 4;

    // *************************************************************************
    // Word widths.
    // *************************************************************************
    localparam int PIX_W = 8;

    // Wide enough for a full row of 255s.
    localparam int SUM_W = 12;

    localparam int COL_W = 10;
    localparam int ROW_W = 3;

endpackage
